// ==== logic/fetch_macros.svh ====
////////////////////
// fetch front end sizes
// widths, queue depth, memory latency, reset pc
////////////////////

`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// pc and fetch address width
`define ADDR_W    64
// one 32-bit instruction per fetch
`define INST_W    32
// reset pc
`define PC_START  64'h0000_0000_0000_0000

// instruction memory geometry, words and word index width
`define ROM_WORDS 64
`define ROM_AW    6
// request to response, in cycles
`define MEM_LAT   2

// decode queue slots, also the initial credit count
`define BUF_DEPTH 4
`define CREDIT_W  3
// two redirects at most per latency window, so 2 bits never alias
`define EPOCH_W   2

`endif

// ==== logic/fetch_pkg.sv ====
////////////////////
// fetch types
////////////////////

`default_nettype none

package fetch_pkg;

  // controller states
  // FETCH  issuing one request per cycle
  // STALL  out of decode credits
  // FAULT  stopped on a bad address, waits for a redirect
  typedef enum logic [1:0] {
    FETCH = 2'd0,
    STALL = 2'd1,
    FAULT = 2'd2
  } fetch_state_t;

  // memory response code
  typedef enum logic {
    RESP_OKAY   = 1'b0,
    RESP_DECERR = 1'b1
  } mem_resp_t;

endpackage

`default_nettype wire

// ==== logic/credit_counter.sv ====
////////////////////
// decode queue credits
// one credit per free slot in decode
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module credit_counter (
  input  logic clk,
  input  logic rst,
  // one per issued request
  input  logic consume,
  // one per dropped response
  input  logic refund,
  // one per instruction decode took
  input  logic credit_return,
  output logic credit_avail
);

  // free slot count
  logic [`CREDIT_W-1:0] credits;
  logic [`CREDIT_W-1:0] credits_next;

  ////////////////////
  // count update
  ////////////////////

  // refund and return can land together, both add
  always_comb begin
    credits_next = credits
                 + `CREDIT_W'(refund)
                 + `CREDIT_W'(credit_return)
                 - `CREDIT_W'(consume);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      // decode queue starts empty
      credits <= `CREDIT_W'(`BUF_DEPTH);
    end else begin
      credits <= credits_next;
    end
  end

  // issue allowed while any slot is free
  assign credit_avail = (credits != '0);

endmodule

`default_nettype wire

// ==== logic/inst_rom.sv ====
////////////////////
// instruction memory
// load port for boot, fixed-latency pipelined read
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module inst_rom
  import fetch_pkg::*;
(
  input  logic                clk,
  input  logic                req_valid,
  input  logic [`ADDR_W-1:0]  req_addr,
  input  logic [`EPOCH_W-1:0] req_epoch,
  input  logic                load_en,
  input  logic [`ROM_AW-1:0]  load_addr,
  input  logic [`INST_W-1:0]  load_data,
  output logic                rsp_valid,
  output logic [`INST_W-1:0]  rsp_data,
  output mem_resp_t           rsp_resp,
  output logic [`EPOCH_W-1:0] rsp_epoch
);

  // word storage
  logic [`INST_W-1:0]  mem [`ROM_WORDS];

  // address decode
  logic [`ROM_AW-1:0]  word_idx;
  logic                in_range;
  logic [`INST_W-1:0]  rd_data;
  mem_resp_t           rd_resp;

  // read pipeline, stage 0 is captured on the request edge
  logic                pipe_valid [`MEM_LAT];
  logic [`INST_W-1:0]  pipe_data  [`MEM_LAT];
  mem_resp_t           pipe_resp  [`MEM_LAT];
  logic [`EPOCH_W-1:0] pipe_epoch [`MEM_LAT];

  ////////////////////
  // boot load
  ////////////////////

  // a write is seen by a request one cycle later
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  ////////////////////
  // read
  ////////////////////

  // byte address to word index
  assign word_idx = req_addr[`ROM_AW+1:2];
  assign in_range = (req_addr >> 2) < `ADDR_W'(`ROM_WORDS);

  // outside the array gives zero data and DECERR
  assign rd_data = in_range ? mem[word_idx] : '0;
  assign rd_resp = in_range ? RESP_OKAY : RESP_DECERR;

  // no reset here, idle requests flush the valid bits
  always_ff @(posedge clk) begin
    pipe_valid[0] <= req_valid;
    pipe_data[0]  <= rd_data;
    pipe_resp[0]  <= rd_resp;
    pipe_epoch[0] <= req_epoch;
    for (int i = 1; i < `MEM_LAT; i++) begin
      pipe_valid[i] <= pipe_valid[i-1];
      pipe_data[i]  <= pipe_data[i-1];
      pipe_resp[i]  <= pipe_resp[i-1];
      pipe_epoch[i] <= pipe_epoch[i-1];
    end
  end

  // last stage is the response, MEM_LAT cycles after the request
  assign rsp_valid = pipe_valid[`MEM_LAT-1];
  assign rsp_data  = pipe_data[`MEM_LAT-1];
  assign rsp_resp  = pipe_resp[`MEM_LAT-1];
  assign rsp_epoch = pipe_epoch[`MEM_LAT-1];

endmodule

`default_nettype wire

// ==== logic/fetch_ctrl.sv ====
////////////////////
// fetch controller
// pc sequencing, epoch filtering of responses, delivery to decode
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_ctrl
  import fetch_pkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                redirect,
  input  logic [`ADDR_W-1:0]  redirect_pc,
  input  logic                credit_avail,
  input  logic                rsp_valid,
  input  logic [`INST_W-1:0]  rsp_data,
  input  mem_resp_t           rsp_resp,
  input  logic [`EPOCH_W-1:0] rsp_epoch,
  output logic                consume,
  output logic                refund,
  output logic                req_valid,
  output logic [`ADDR_W-1:0]  req_addr,
  output logic [`EPOCH_W-1:0] req_epoch,
  output logic                inst_valid,
  output logic [`INST_W-1:0]  inst,
  output logic [`ADDR_W-1:0]  inst_pc,
  output logic [`ADDR_W-1:0]  inst_pred_pc,
  output logic                fetch_fault
);

  fetch_state_t        state;
  fetch_state_t        state_next;
  logic [`ADDR_W-1:0]  pc;
  logic [`EPOCH_W-1:0] epoch;
  logic [`ADDR_W-1:0]  redirect_tgt;
  logic [`ADDR_W-1:0]  issue_addr;
  logic                issue;
  logic                rsp_match;
  logic                deliver;
  logic                fault_hit;
  logic [`ADDR_W-1:0]  rsp_pc;
  // pc of each request in flight, aligned with the memory pipeline
  logic [`ADDR_W-1:0]  pc_pipe [`MEM_LAT];

  ////////////////////
  // issue side
  ////////////////////

  // low two bits of the target dropped
  assign redirect_tgt = {redirect_pc[`ADDR_W-1:2], 2'b00};
  assign issue_addr   = redirect ? redirect_tgt : pc;

  // a redirect restarts issue even from FAULT
  assign issue   = (redirect || state != FAULT) && credit_avail;
  assign consume = issue;

  ////////////////////
  // response side
  ////////////////////

  assign rsp_match = (rsp_epoch == epoch);
  assign rsp_pc    = pc_pipe[`MEM_LAT-1];

  // current stream, good data, not stopped
  assign deliver = rsp_valid && rsp_match && rsp_resp == RESP_OKAY && state != FAULT;

  // bad address on the live stream
  // a redirect in the same cycle makes it old-stream, so no fault
  assign fault_hit = rsp_valid && rsp_match && rsp_resp == RESP_DECERR &&
                     state != FAULT && !redirect;

  // whatever is not delivered gives its slot back
  assign refund = rsp_valid && !deliver;

  assign fetch_fault = (state == FAULT);

  // next state
  always_comb begin
    state_next = state;
    if (redirect) begin
      state_next = credit_avail ? FETCH : STALL;
    end else if (fault_hit) begin
      state_next = FAULT;
    end else if (state != FAULT) begin
      // stall tracks cycles with no credit left
      state_next = credit_avail ? FETCH : STALL;
    end
  end

  // control registers
  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= FETCH;
      pc         <= `PC_START;
      epoch      <= '0;
      req_valid  <= 1'b0;
      inst_valid <= 1'b0;
    end else begin
      state      <= state_next;
      req_valid  <= issue;
      inst_valid <= deliver;
      if (redirect) begin
        epoch <= epoch + 1'b1;
      end
      // pc points at the next word to request
      if (issue) begin
        pc <= issue_addr + `ADDR_W'd4;
      end else if (redirect) begin
        pc <= redirect_tgt;
      end
    end
  end

  // request and delivery payload
  always_ff @(posedge clk) begin
    if (issue) begin
      req_addr  <= issue_addr;
      // new-stream requests carry the advanced epoch
      req_epoch <= redirect ? epoch + 1'b1 : epoch;
    end
    pc_pipe[0] <= req_addr;
    for (int i = 1; i < `MEM_LAT; i++) begin
      pc_pipe[i] <= pc_pipe[i-1];
    end
    if (deliver) begin
      inst         <= rsp_data;
      inst_pc      <= rsp_pc;
      // sequential prediction only
      inst_pred_pc <= rsp_pc + `ADDR_W'd4;
    end
  end

endmodule

`default_nettype wire

// ==== logic/fetch_top.sv ====
////////////////////
// fetch front end top
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_top
  import fetch_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  // from execute
  input  logic               redirect,
  input  logic [`ADDR_W-1:0] redirect_pc,
  // from decode
  input  logic               credit_return,
  // boot load
  input  logic               load_en,
  input  logic [`ROM_AW-1:0] load_addr,
  input  logic [`INST_W-1:0] load_data,
  // to decode
  output logic               inst_valid,
  output logic [`INST_W-1:0] inst,
  output logic [`ADDR_W-1:0] inst_pc,
  output logic [`ADDR_W-1:0] inst_pred_pc,
  output logic               fetch_fault
);

  // credit handshake
  logic                consume;
  logic                refund;
  logic                credit_avail;

  // request port
  logic                req_valid;
  logic [`ADDR_W-1:0]  req_addr;
  logic [`EPOCH_W-1:0] req_epoch;

  // response port
  logic                rsp_valid;
  logic [`INST_W-1:0]  rsp_data;
  mem_resp_t           rsp_resp;
  logic [`EPOCH_W-1:0] rsp_epoch;

  fetch_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .credit_avail (credit_avail),
    .rsp_valid    (rsp_valid),
    .rsp_data     (rsp_data),
    .rsp_resp     (rsp_resp),
    .rsp_epoch    (rsp_epoch),
    .consume      (consume),
    .refund       (refund),
    .req_valid    (req_valid),
    .req_addr     (req_addr),
    .req_epoch    (req_epoch),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_pc      (inst_pc),
    .inst_pred_pc (inst_pred_pc),
    .fetch_fault  (fetch_fault)
  );

  credit_counter u_credit (
    .clk           (clk),
    .rst           (rst),
    .consume       (consume),
    .refund        (refund),
    .credit_return (credit_return),
    .credit_avail  (credit_avail)
  );

  inst_rom u_rom (
    .clk       (clk),
    .req_valid (req_valid),
    .req_addr  (req_addr),
    .req_epoch (req_epoch),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .rsp_valid (rsp_valid),
    .rsp_data  (rsp_data),
    .rsp_resp  (rsp_resp),
    .rsp_epoch (rsp_epoch)
  );

endmodule

`default_nettype wire

// ==== verification/fetch_assertions.sv ====
////////////////////
// fetch checker
// credit bound, issue gating, no delivery while faulted
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_assertions (
  input logic                 clk,
  input logic                 rst,
  input logic [`CREDIT_W-1:0] credits,
  input logic                 consume,
  input logic                 credit_avail,
  input logic                 inst_valid,
  input logic                 fetch_fault
);

  // decode queue has only BUF_DEPTH slots
  credit_bound: assert property (@(posedge clk) disable iff (rst)
    credits <= `CREDIT_W'(`BUF_DEPTH))
    else $error("credit count above decode queue depth");

  // a request needs a free slot
  consume_gated: assert property (@(posedge clk) disable iff (rst)
    consume |-> credit_avail)
    else $error("request issued with no credit");

  // FAULT delivers nothing
  no_fault_delivery: assert property (@(posedge clk) disable iff (rst)
    inst_valid |-> !fetch_fault)
    else $error("instruction delivered while faulted");

endmodule

// counter side, delivery pins tied low
bind credit_counter fetch_assertions u_credit_chk (
  .clk          (clk),
  .rst          (rst),
  .credits      (credits),
  .consume      (consume),
  .credit_avail (credit_avail),
  .inst_valid   (1'b0),
  .fetch_fault  (1'b0)
);

// controller side, credit pins tied low
bind fetch_ctrl fetch_assertions u_ctrl_chk (
  .clk          (clk),
  .rst          (rst),
  .credits      ({`CREDIT_W{1'b0}}),
  .consume      (1'b0),
  .credit_avail (1'b0),
  .inst_valid   (inst_valid),
  .fetch_fault  (fetch_fault)
);

`default_nettype wire

// ==== verification/fetch_tb.sv ====
////////////////////
// fetch front end testbench
// decode model, reference fetch, stream comparison
////////////////////

`timescale 1ns/1ns
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;

  logic               clk = 1'b0;
  logic               rst = 1'b1;
  logic               redirect = 1'b0;
  logic [`ADDR_W-1:0] redirect_pc = '0;
  logic               credit_return = 1'b0;
  logic               load_en = 1'b0;
  logic [`ROM_AW-1:0] load_addr = '0;
  logic [`INST_W-1:0] load_data = '0;
  logic               inst_valid;
  logic [`INST_W-1:0] inst;
  logic [`ADDR_W-1:0] inst_pc;
  logic [`ADDR_W-1:0] inst_pred_pc;
  logic               fetch_fault;

  // program image as loaded
  logic [`INST_W-1:0] rom_copy [`ROM_WORDS];
  // decode queue, pcs of held instructions
  logic [`ADDR_W-1:0] dq [$];
  int                 pop_pct = 50;

  // comparison state
  logic [`ADDR_W-1:0] exp_pc;
  logic [`ADDR_W-1:0] old_pc;
  int                 cycle;
  int                 redir_cycle;
  logic               redir_seen;
  logic               fault_prev;
  int                 deliv_count = 0;

  // one counter per process
  int errors = 0;
  int overflows = 0;
  int flow_errors = 0;
  int timeouts = 0;

  fetch_top UUT (
    .clk          (clk),
    .rst          (rst),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .credit_return(credit_return),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .inst_pc      (inst_pc),
    .inst_pred_pc (inst_pred_pc),
    .fetch_fault  (fetch_fault)
  );

  always #5 clk = ~clk;

  ////////////////////
  // reference model
  ////////////////////

  // {fault, word} for a fetch at pc
  function automatic logic [`INST_W:0] fetch_ref(input logic [`ADDR_W-1:0] pc);
    logic [`ADDR_W-1:0] word;
    word = pc >> 2;
    if (word >= `ADDR_W'(`ROM_WORDS)) begin
      fetch_ref = {1'b1, `INST_W'(0)};
    end else begin
      fetch_ref = {1'b0, rom_copy[word[`ROM_AW-1:0]]};
    end
  endfunction

  // aligned word with room for a few more, low bits left as junk
  function automatic logic [`ADDR_W-1:0] random_target();
    logic [`ADDR_W-1:0] word;
    word = `ADDR_W'($urandom % (`ROM_WORDS - 8));
    random_target = (word << 2) | `ADDR_W'($urandom % 4);
  endfunction

  task automatic check_delivery(input logic [`ADDR_W-1:0] pc);
    logic [`INST_W:0] ref_val;
    ref_val = fetch_ref(pc);
    if (inst_pc !== pc) begin
      $display("error at %0t: inst_pc %h, expected %h", $time, inst_pc, pc);
      errors++;
    end
    if (ref_val[`INST_W]) begin
      $display("error at %0t: delivery for pc %h outside memory", $time, pc);
      errors++;
    end else if (inst !== ref_val[`INST_W-1:0]) begin
      $display("error at %0t: inst %h at pc %h, expected %h", $time, inst, pc,
               ref_val[`INST_W-1:0]);
      errors++;
    end
    if (inst_pred_pc !== pc + `ADDR_W'd4) begin
      $display("error at %0t: inst_pred_pc %h at pc %h", $time, inst_pred_pc, pc);
      errors++;
    end
  endtask

  // sampled at the edge, so each value is the one of the cycle just ended
  always @(posedge clk) begin : compare
    logic [`INST_W:0] ref_val;
    if (rst) begin
      exp_pc      = `PC_START;
      old_pc      = `PC_START;
      cycle       = 0;
      redir_cycle = 0;
      redir_seen  = 1'b0;
      fault_prev  = 1'b0;
    end else begin
      cycle++;
      if (inst_valid) begin
        // cycle right after a redirect may still carry the old stream
        if (redir_seen && cycle == redir_cycle + 1) begin
          check_delivery(old_pc);
          old_pc = old_pc + `ADDR_W'd4;
        end else begin
          check_delivery(exp_pc);
          exp_pc = exp_pc + `ADDR_W'd4;
        end
        deliv_count++;
      end
      // fault only once the stream has walked off the end
      if (fetch_fault && !fault_prev) begin
        ref_val = fetch_ref(exp_pc);
        if (!ref_val[`INST_W]) begin
          $display("error at %0t: fault with next pc %h inside memory", $time, exp_pc);
          errors++;
        end
      end
      fault_prev = fetch_fault;
      if (redirect) begin
        old_pc      = exp_pc;
        // target is word aligned, low two bits ignored
        exp_pc      = redirect_pc & ~`ADDR_W'(3);
        redir_cycle = cycle;
        redir_seen  = 1'b1;
      end
    end
  end

  ////////////////////
  // decode model
  ////////////////////

  always @(posedge clk) begin
    if (rst) begin
      dq.delete();
      credit_return <= 1'b0;
    end else begin
      if (inst_valid) begin
        dq.push_back(inst_pc);
        if (dq.size() > `BUF_DEPTH) begin
          $display("error at %0t: decode queue holds %0d entries", $time, dq.size());
          overflows++;
        end
      end
      // random pop, one credit back per pop
      if (dq.size() > 0 && ($urandom % 100) < pop_pct) begin
        void'(dq.pop_front());
        credit_return <= 1'b1;
      end else begin
        credit_return <= 1'b0;
      end
    end
  end

  // reset for 16 cycles, program load runs on ahead of fetch
  initial begin : boot
    int seed_ret;
    seed_ret = $urandom(48);
    for (int i = 0; i < `ROM_WORDS; i++) begin
      rom_copy[`ROM_AW'(i)] = $urandom;
    end
    for (int i = 0; i < `ROM_WORDS; i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= `ROM_AW'(i);
      load_data <= rom_copy[`ROM_AW'(i)];
      if (i == 15) begin
        rst <= 1'b0;
      end
    end
    @(posedge clk);
    load_en <= 1'b0;
  end

  ////////////////////
  // test flow
  ////////////////////

  task automatic send_redirect(input logic [`ADDR_W-1:0] target);
    @(posedge clk);
    redirect    <= 1'b1;
    redirect_pc <= target;
    @(posedge clk);
    redirect    <= 1'b0;
  endtask

  // two redirects in consecutive cycles
  task automatic send_redirect_pair(input logic [`ADDR_W-1:0] t1, input logic [`ADDR_W-1:0] t2);
    @(posedge clk);
    redirect    <= 1'b1;
    redirect_pc <= t1;
    @(posedge clk);
    redirect_pc <= t2;
    @(posedge clk);
    redirect    <= 1'b0;
  endtask

  task automatic wait_deliveries(input int n, input int limit);
    int start;
    int waited;
    waited = 0;
    if (timeouts == 0) begin
      // count from mid cycle, clear of the compare process
      @(negedge clk);
      start = deliv_count;
      while (deliv_count < start + n && waited < limit) begin
        @(negedge clk);
        waited++;
      end
      if (deliv_count < start + n) begin
        $display("timeout: %0d of %0d instructions delivered", deliv_count - start, n);
        timeouts++;
      end
    end
  endtask

  task automatic wait_fault(input logic level, input int limit);
    int waited;
    waited = 0;
    if (timeouts == 0) begin
      while (fetch_fault !== level && waited < limit) begin
        @(negedge clk);
        waited++;
      end
      if (fetch_fault !== level) begin
        $display("timeout: fetch_fault never went to %0d", level);
        timeouts++;
      end
    end
  endtask

  initial begin : main
    int waited;
    int held;
    waited = 0;
    while (rst && waited < 100) begin
      @(negedge clk);
      waited++;
    end
    if (rst) begin
      $display("timeout: reset never released");
      timeouts++;
    end
    // sequential stream from reset pc
    wait_deliveries(16, 200);
    // decode barely pops, fetch must stall on credits
    pop_pct = 5;
    repeat (150) @(posedge clk);
    pop_pct = 60;
    wait_deliveries(16, 400);
    // run off the end of memory
    pop_pct = 50;
    wait_fault(1'b1, 2000);
    held = deliv_count;
    repeat (20) @(negedge clk);
    if (deliv_count != held) begin
      $display("error at %0t: %0d deliveries while faulted", $time, deliv_count - held);
      flow_errors++;
    end
    send_redirect(random_target());
    wait_fault(1'b0, 10);
    wait_deliveries(4, 200);
    // random redirects, some back to back
    for (int k = 0; k < 12; k++) begin
      repeat (4 + $urandom % 12) @(posedge clk);
      if ($urandom % 3 == 0) begin
        send_redirect_pair(random_target(), random_target());
      end else begin
        send_redirect(random_target());
      end
      wait_deliveries(2, 200);
    end
    // long free run, refunded credits must all be back
    pop_pct = 90;
    send_redirect(`PC_START);
    wait_fault(1'b0, 10);
    wait_deliveries(48, 1000);
    wait_fault(1'b1, 1000);
    repeat (10) @(posedge clk);
    $display("errors %0d, queue overflows %0d, flow errors %0d, timeouts %0d",
             errors, overflows, flow_errors, timeouts);
    if (errors == 0 && overflows == 0 && flow_errors == 0 && timeouts == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+logic
logic/fetch_pkg.sv
logic/credit_counter.sv
logic/inst_rom.sv
logic/fetch_ctrl.sv
logic/fetch_top.sv
verification/fetch_assertions.sv
verification/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the fetch testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns -Mdir obj_dir \
  --top-module fetch_tb -f build.f || { echo "build failed"; exit 1; }
out=$(./obj_dir/Vfetch_tb)
echo "$out"
echo "$out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1
